// File: logic/bps_pkg.sv
package bps_pkg;

    // field geometry
    localparam int FIELD_W = 4;
    localparam int FIELD_H = 4;
    localparam int NUM_CELLS = FIELD_W * FIELD_H;
    localparam int NUM_LABELS = 16;

    // per-label widths
    localparam int DATA_W = 8;
    localparam int MSG_W = 6;
    localparam int COST_W = DATA_W + 1;
    localparam int PENALTY = 12;

    localparam int ADDR_W = 48;
    localparam int BUS_W = 64;
    localparam int WORD_BYTES = BUS_W / 8;
    localparam int CELL_BYTES = 2 * WORD_BYTES;
    localparam int DATA_OFFSET = 40;
    localparam int MSG_OFFSET = DATA_OFFSET + NUM_CELLS * CELL_BYTES;

    // issue to result latency of a sweep cell
    localparam int PIPE_LAT = 3;
    localparam int SWEEP_LAST = NUM_CELLS + PIPE_LAT - 1;
    localparam int SWEEP_CNT_W = $clog2(SWEEP_LAST + 1);

    typedef logic [$clog2(NUM_CELLS)-1:0] cell_addr_t;
    typedef logic [$clog2(FIELD_H)-1:0] row_t;
    typedef logic [NUM_LABELS*DATA_W-1:0] data_vec_t;
    typedef logic [NUM_LABELS*MSG_W-1:0] msg_vec_t;
    typedef logic [BUS_W-1:0] bus_word_t;
    typedef logic [ADDR_W-1:0] bus_addr_t;

    typedef enum logic [1:0] {OP_IDLE, OP_LOAD, OP_SWEEP, OP_STORE} opcode_t;

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_SWEEP, ST_STORE} seq_state_t;

endpackage

// File: logic/bps_top.sv
`timescale 1ns/1ps

module bps_top
    import bps_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  opcode_t   opcode,
    input  bus_addr_t addr_base,
    output logic      busy,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output bus_addr_t wb_adr,
    output bus_word_t wb_dat_w,
    input  bus_word_t wb_dat_r,
    input  logic      wb_ack
);

    logic       xfer_start;
    logic       xfer_write;
    bus_addr_t  xfer_addr;
    data_vec_t  xfer_wdata;
    logic       xfer_done;
    data_vec_t  xfer_rdata;
    logic       data_wr_en;
    cell_addr_t data_wr_addr;
    cell_addr_t data_rd_addr;
    data_vec_t  data_wr_data;
    data_vec_t  data_rd_data;
    logic       msg_wr_en;
    cell_addr_t msg_wr_addr;
    cell_addr_t msg_rd_addr;
    msg_vec_t   msg_wr_data;
    msg_vec_t   msg_rd_data;
    logic       upd_in_valid;
    msg_vec_t   upd_in_msg;
    logic       upd_out_valid;
    msg_vec_t   upd_out_msg;

    sweep_sequencer u_seq (
        .clk(clk), .rst(rst), .opcode(opcode), .addr_base(addr_base), .busy(busy),
        .xfer_start(xfer_start), .xfer_write(xfer_write), .xfer_addr(xfer_addr),
        .xfer_wdata(xfer_wdata), .xfer_done(xfer_done), .xfer_rdata(xfer_rdata),
        .data_wr_en(data_wr_en), .data_wr_addr(data_wr_addr), .data_rd_addr(data_rd_addr),
        .data_wr_data(data_wr_data), .msg_wr_en(msg_wr_en), .msg_wr_addr(msg_wr_addr),
        .msg_rd_addr(msg_rd_addr), .msg_wr_data(msg_wr_data), .msg_rd_data(msg_rd_data),
        .upd_in_valid(upd_in_valid), .upd_in_msg(upd_in_msg),
        .upd_out_valid(upd_out_valid), .upd_out_msg(upd_out_msg)
    );

    bus_engine u_engine (
        .clk(clk), .rst(rst), .xfer_start(xfer_start), .xfer_write(xfer_write),
        .xfer_addr(xfer_addr), .xfer_wdata(xfer_wdata), .xfer_done(xfer_done),
        .xfer_rdata(xfer_rdata), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    message_update u_update (
        .clk(clk), .rst(rst), .in_valid(upd_in_valid), .data(data_rd_data),
        .in_msg(upd_in_msg), .out_valid(upd_out_valid), .out_msg(upd_out_msg)
    );

    cell_ram #(.WIDTH($bits(data_vec_t))) data_ram (
        .clk(clk), .wr_en(data_wr_en), .wr_addr(data_wr_addr), .rd_addr(data_rd_addr),
        .wr_data(data_wr_data), .rd_data(data_rd_data)
    );

    cell_ram #(.WIDTH($bits(msg_vec_t))) msg_ram (
        .clk(clk), .wr_en(msg_wr_en), .wr_addr(msg_wr_addr), .rd_addr(msg_rd_addr),
        .wr_data(msg_wr_data), .rd_data(msg_rd_data)
    );

endmodule

// File: logic/bus_engine.sv
`timescale 1ns/1ps

module bus_engine
    import bps_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      xfer_start,
    input  logic      xfer_write,
    input  bus_addr_t xfer_addr,
    input  data_vec_t xfer_wdata,
    output logic      xfer_done,
    output data_vec_t xfer_rdata,
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output bus_addr_t wb_adr,
    output bus_word_t wb_dat_w,
    input  bus_word_t wb_dat_r,
    input  logic      wb_ack
);

    typedef enum logic [1:0] {E_IDLE, E_LOW, E_GAP, E_HIGH} eng_state_t;

    eng_state_t state;
    bus_addr_t  addr_q;
    bus_word_t  high_q;
    bus_word_t  low_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= E_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (xfer_start) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we <= xfer_write;
                        state <= E_LOW;
                    end
                end
                E_LOW: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state <= E_GAP;
                    end
                end
                // idle cycle between the two words
                E_GAP: begin
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    state <= E_HIGH;
                end
                E_HIGH: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we <= 1'b0;
                        xfer_done <= 1'b1;
                        state <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            E_IDLE: begin
                if (xfer_start) begin
                    addr_q <= xfer_addr;
                    high_q <= xfer_wdata[2*BUS_W-1:BUS_W];
                    wb_adr <= xfer_addr;
                    wb_dat_w <= xfer_wdata[BUS_W-1:0];
                end
            end
            E_LOW: begin
                if (wb_ack) begin
                    low_q <= wb_dat_r;
                end
            end
            E_GAP: begin
                wb_adr <= addr_q + bus_addr_t'(WORD_BYTES);
                wb_dat_w <= high_q;
            end
            E_HIGH: begin
                if (wb_ack) begin
                    xfer_rdata <= {wb_dat_r, low_q};
                end
            end
            default: ;
        endcase
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

    // sequencer must wait for xfer_done
    a_start_idle: assert property (@(posedge clk) disable iff (rst) xfer_start |-> state == E_IDLE);

endmodule

// File: logic/cell_ram.sv
`timescale 1ns/1ps

module cell_ram
    import bps_pkg::*;
#(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             wr_en,
    input  cell_addr_t       wr_addr,
    input  cell_addr_t       rd_addr,
    input  logic [WIDTH-1:0] wr_data,
    output logic [WIDTH-1:0] rd_data
);

    logic [WIDTH-1:0] mem [NUM_CELLS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/message_update.sv
`timescale 1ns/1ps

module message_update
    import bps_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  data_vec_t data,
    input  msg_vec_t  in_msg,
    output logic      out_valid,
    output msg_vec_t  out_msg
);

    logic [COST_W-1:0] cost_q [NUM_LABELS];
    logic              valid_q;
    logic [COST_W-1:0] min_cost;
    msg_vec_t          next_msg;

    // stage 1 adds data cost and incoming message
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LABELS; l++) begin
            cost_q[l] <= COST_W'(data[l*DATA_W +: DATA_W]) + COST_W'(in_msg[l*MSG_W +: MSG_W]);
        end
    end

    always_comb begin
        min_cost = cost_q[0];
        for (int l = 1; l < NUM_LABELS; l++) begin
            if (cost_q[l] < min_cost) begin
                min_cost = cost_q[l];
            end
        end
    end

    // normalize and clamp to the Potts penalty
    always_comb begin : clamp
        logic [COST_W-1:0] diff;
        next_msg = '0;
        for (int l = 0; l < NUM_LABELS; l++) begin
            diff = cost_q[l] - min_cost;
            if (diff > COST_W'(PENALTY)) begin
                next_msg[l*MSG_W +: MSG_W] = MSG_W'(PENALTY);
            end else begin
                next_msg[l*MSG_W +: MSG_W] = diff[MSG_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        out_msg <= next_msg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q <= in_valid;
            out_valid <= valid_q;
        end
    end

endmodule

// File: logic/sweep_sequencer.sv
`timescale 1ns/1ps

module sweep_sequencer
    import bps_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  opcode_t    opcode,
    input  bus_addr_t  addr_base,
    output logic       busy,
    output logic       xfer_start,
    output logic       xfer_write,
    output bus_addr_t  xfer_addr,
    output data_vec_t  xfer_wdata,
    input  logic       xfer_done,
    input  data_vec_t  xfer_rdata,
    output logic       data_wr_en,
    output cell_addr_t data_wr_addr,
    output cell_addr_t data_rd_addr,
    output data_vec_t  data_wr_data,
    output logic       msg_wr_en,
    output cell_addr_t msg_wr_addr,
    output cell_addr_t msg_rd_addr,
    output msg_vec_t   msg_wr_data,
    input  msg_vec_t   msg_rd_data,
    output logic       upd_in_valid,
    output msg_vec_t   upd_in_msg,
    input  logic       upd_out_valid,
    input  msg_vec_t   upd_out_msg
);

    seq_state_t             state;
    bus_addr_t              base_q;
    cell_addr_t             cell_cnt;
    logic [SWEEP_CNT_W-1:0] sweep_cnt;
    logic                   xfer_busy;
    logic                   rd_ready;
    logic                   issue;
    row_t                   issue_row;
    logic [1:0]             issue_col;
    cell_addr_t             issue_cell;
    logic [PIPE_LAT-1:0]    pipe_valid;
    cell_addr_t             pipe_cell [PIPE_LAT];
    row_t                   pipe_row [PIPE_LAT];
    msg_vec_t               fwd [FIELD_H];

    // rows interleaved at one cell per cycle
    assign issue = (state == ST_SWEEP) && (sweep_cnt < SWEEP_CNT_W'(NUM_CELLS));
    assign issue_row = sweep_cnt[1:0];
    assign issue_col = sweep_cnt[3:2];
    assign issue_cell = {issue_row, issue_col};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cell_cnt <= '0;
            sweep_cnt <= '0;
            xfer_busy <= 1'b0;
            rd_ready <= 1'b0;
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[PIPE_LAT-2:0], issue};
            case (state)
                ST_IDLE: begin
                    cell_cnt <= '0;
                    sweep_cnt <= '0;
                    xfer_busy <= 1'b0;
                    rd_ready <= 1'b0;
                    case (opcode)
                        OP_LOAD: state <= ST_LOAD;
                        OP_SWEEP: state <= ST_SWEEP;
                        OP_STORE: state <= ST_STORE;
                        default: ;
                    endcase
                end
                ST_LOAD, ST_STORE: begin
                    // message ram read needs one cycle before each store
                    rd_ready <= !xfer_done;
                    if (xfer_start) begin
                        xfer_busy <= 1'b1;
                    end
                    if (xfer_done) begin
                        xfer_busy <= 1'b0;
                        cell_cnt <= cell_cnt + 1'b1;
                        if (cell_cnt == cell_addr_t'(NUM_CELLS - 1)) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == SWEEP_CNT_W'(SWEEP_LAST)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            base_q <= addr_base;
        end
        pipe_cell[0] <= issue_cell;
        pipe_row[0] <= issue_row;
        for (int i = 1; i < PIPE_LAT; i++) begin
            pipe_cell[i] <= pipe_cell[i-1];
            pipe_row[i] <= pipe_row[i-1];
        end
        // first cell of a row sees a zero message
        if (issue && issue_col == 2'd0) begin
            fwd[issue_row] <= '0;
        end
        if (upd_out_valid) begin
            fwd[pipe_row[PIPE_LAT-1]] <= upd_out_msg;
        end
    end

    assign busy = (state != ST_IDLE);
    assign xfer_write = (state == ST_STORE);
    assign xfer_start = !xfer_busy && ((state == ST_LOAD) || (state == ST_STORE && rd_ready));
    assign xfer_addr = base_q
                     + (xfer_write ? bus_addr_t'(MSG_OFFSET) : bus_addr_t'(DATA_OFFSET))
                     + bus_addr_t'(cell_cnt) * bus_addr_t'(CELL_BYTES);

    // zero-extend each message entry to a byte
    always_comb begin
        xfer_wdata = '0;
        for (int l = 0; l < NUM_LABELS; l++) begin
            xfer_wdata[l*DATA_W +: DATA_W] = DATA_W'(msg_rd_data[l*MSG_W +: MSG_W]);
        end
    end

    assign data_wr_en = (state == ST_LOAD) && xfer_done;
    assign data_wr_addr = cell_cnt;
    assign data_wr_data = xfer_rdata;
    assign data_rd_addr = issue_cell;

    assign upd_in_valid = pipe_valid[0];
    assign upd_in_msg = fwd[pipe_row[0]];

    assign msg_rd_addr = cell_cnt;
    assign msg_wr_en = upd_out_valid;
    assign msg_wr_addr = pipe_cell[PIPE_LAT-1];
    // last column has no right neighbour
    assign msg_wr_data = (msg_wr_addr[1:0] == 2'(FIELD_W - 1)) ? '0 : upd_out_msg;

    a_upd_latency: assert property (@(posedge clk) disable iff (rst)
        upd_out_valid == pipe_valid[PIPE_LAT-1]);

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bps_tb -Mdir obj_dir -o bps_sim -f sim.f \
    && ./obj_dir/bps_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
logic/bps_pkg.sv
logic/cell_ram.sv
logic/message_update.sv
logic/bus_engine.sv
logic/sweep_sequencer.sv
logic/bps_top.sv
tb/mem_model.sv
tb/bps_tb.sv

// File: tb/bps_tb.sv
`timescale 1ns/1ps

module bps_tb
    import bps_pkg::*;
();

    typedef enum int {PAT_ZERO, PAT_RAND, PAT_RAMP} pattern_t;

    typedef struct {
        int       base;
        pattern_t kind;
        int       max_wait;
        bit       stray;
    } test_t;

    localparam int NUM_TESTS = 6;
    localparam int MEM_WORDS = 512;
    localparam logic [31:0] SEED = 32'hdccc93dc;

    logic       clk;
    logic       rst;
    opcode_t    opcode;
    bus_addr_t  addr_base;
    logic       busy;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    bus_addr_t  wb_adr;
    bus_word_t  wb_dat_w;
    bus_word_t  wb_dat_r;
    logic       wb_ack;
    logic [7:0] ack_wait;

    test_t       tests [NUM_TESTS];
    bus_word_t   exp_mem [MEM_WORDS];
    int          costs [NUM_CELLS][NUM_LABELS];
    logic [31:0] lcg_state;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;

    bps_top UUT (
        .clk(clk), .rst(rst), .opcode(opcode), .addr_base(addr_base), .busy(busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    mem_model slave (
        .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack), .wait_cycles(ack_wait)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, a command never finished", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function bus_word_t fill_word(int idx);
        logic [31:0] a;
        a = 32'(idx);
        return {a * 32'h9e3779b1, ~a ^ 32'h5a5a0f0f};
    endfunction

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic write_word(input int idx, input bus_word_t w);
        slave.mem[9'(idx)] = w;
        exp_mem[9'(idx)] = w;
    endtask

    // data costs into the data region with label 0 in the low byte
    task automatic load_pattern(input test_t t);
        bus_word_t lo;
        bus_word_t hi;
        int        idx;
        if (t.kind == PAT_RAND) begin
            lcg_state = SEED ^ 32'(t.base);
        end
        for (int c = 0; c < NUM_CELLS; c++) begin
            lo = '0;
            hi = '0;
            for (int l = 0; l < NUM_LABELS; l++) begin
                case (t.kind)
                    PAT_RAND: costs[c][l] = int'(next_random() >> 24);
                    PAT_RAMP: costs[c][l] = (l * 17 + c * 3) % 256;
                    default:  costs[c][l] = 0;
                endcase
                if (l < 8) begin
                    lo[l*8 +: 8] = 8'(costs[c][l]);
                end else begin
                    hi[(l-8)*8 +: 8] = 8'(costs[c][l]);
                end
            end
            idx = (t.base + DATA_OFFSET + CELL_BYTES * c) / 8;
            write_word(idx, lo);
            write_word(idx + 1, hi);
        end
    endtask

    // horizontal min-sum with Potts clamp row by row
    task automatic expect_messages(input test_t t);
        int        in_msg [NUM_LABELS];
        int        cost [NUM_LABELS];
        int        min_c;
        int        c;
        int        idx;
        bus_word_t lo;
        bus_word_t hi;
        for (int r = 0; r < FIELD_H; r++) begin
            for (int l = 0; l < NUM_LABELS; l++) begin
                in_msg[l] = 0;
            end
            for (int col = 0; col < FIELD_W; col++) begin
                c = r * FIELD_W + col;
                min_c = 1 << 30;
                for (int l = 0; l < NUM_LABELS; l++) begin
                    cost[l] = costs[c][l] + in_msg[l];
                    if (cost[l] < min_c) begin
                        min_c = cost[l];
                    end
                end
                lo = '0;
                hi = '0;
                for (int l = 0; l < NUM_LABELS; l++) begin
                    in_msg[l] = (cost[l] - min_c > PENALTY) ? PENALTY : cost[l] - min_c;
                    // rightmost cell keeps an all-zero message
                    if (col != FIELD_W - 1 && l < 8) begin
                        lo[l*8 +: 8] = 8'(in_msg[l]);
                    end else if (col != FIELD_W - 1) begin
                        hi[(l-8)*8 +: 8] = 8'(in_msg[l]);
                    end
                end
                idx = (t.base + MSG_OFFSET + CELL_BYTES * c) / 8;
                exp_mem[9'(idx)] = lo;
                exp_mem[9'(idx + 1)] = hi;
            end
        end
    endtask

    task automatic run_command(input opcode_t op, input int max_wait, input bit stray);
        int      n;
        opcode_t stray_op;
        stray_op = (op == OP_LOAD) ? OP_STORE : OP_LOAD;
        n = 0;
        @(posedge clk);
        opcode <= op;
        // a nonzero limit always gives a nonzero ack delay
        if (max_wait == 0) begin
            ack_wait <= 8'd0;
        end else begin
            ack_wait <= 8'(1 + next_random() % 32'(max_wait));
        end
        @(posedge clk);
        opcode <= OP_IDLE;
        @(negedge clk);
        check_flag("busy", busy, 1'b1);
        while (busy) begin
            @(posedge clk);
            n++;
            // one stray opcode while the command runs
            opcode <= (stray && n == 4) ? stray_op : OP_IDLE;
            @(negedge clk);
        end
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("wb_we", wb_we, 1'b0);
    endtask

    initial begin
        int          max_w;
        int          test_errors;
        int unsigned acks_before;
        tests[0] = '{'h000, PAT_RAND, 0, 1'b0};
        tests[1] = '{'h000, PAT_RAND, 4, 1'b0};
        tests[2] = '{'h000, PAT_ZERO, 1, 1'b0};
        tests[3] = '{'h400, PAT_RAMP, 2, 1'b1};
        tests[4] = '{'h808, PAT_RAND, 3, 1'b1};
        tests[5] = '{'hc00, PAT_RAND, 0, 1'b0};
        max_w = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tests[i].max_wait > max_w) begin
                max_w = tests[i].max_wait;
            end
        end
        limit = NUM_TESTS * 32 * (max_w + 4) * 2 + 200;

        lcg_state = SEED;
        rst = 1'b1;
        opcode = OP_IDLE;
        addr_base = '0;
        ack_wait = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            write_word(i, fill_word(i));
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        repeat (8) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("wb_cyc", wb_cyc, 1'b0);
            check_flag("wb_stb", wb_stb, 1'b0);
            check_flag("wb_we", wb_we, 1'b0);
        end
        $display("test idle: %0d errors", errors);

        for (int i = 0; i < NUM_TESTS; i++) begin
            test_errors = errors;
            acks_before = slave.ack_count;
            load_pattern(tests[i]);
            expect_messages(tests[i]);
            @(posedge clk);
            addr_base <= bus_addr_t'(tests[i].base);
            run_command(OP_LOAD, tests[i].max_wait, tests[i].stray);
            run_command(OP_SWEEP, tests[i].max_wait, tests[i].stray);
            run_command(OP_STORE, tests[i].max_wait, tests[i].stray);
            // 32 words in and 32 words out
            check_word("wb_ack count", bus_word_t'(slave.ack_count - acks_before),
                       bus_word_t'(64));
            for (int w = 0; w < MEM_WORDS; w++) begin
                check_word($sformatf("mem[%0d]", w), slave.mem[9'(w)], exp_mem[9'(w)]);
            end
            $display("test %0d: base %h %s wait %0d stray %0d, %0d errors", i, tests[i].base,
                     tests[i].kind.name(), tests[i].max_wait, tests[i].stray,
                     errors - test_errors);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb/mem_model.sv
`timescale 1ns/1ps

module mem_model
    import bps_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  bus_addr_t  adr,
    input  bus_word_t  dat_w,
    output bus_word_t  dat_r,
    output logic       ack,
    input  logic [7:0] wait_cycles
);

    localparam int DEPTH = 512;

    bus_word_t   mem [DEPTH];
    logic [7:0]  wait_cnt;
    logic        hit;
    int unsigned ack_count;

    // ack once the wait count runs out and never twice in a row
    assign hit = cyc && stb && !ack && (wait_cnt == wait_cycles);

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            wait_cnt <= '0;
            ack_count <= 0;
        end else begin
            ack <= hit;
            if (hit) begin
                wait_cnt <= '0;
                ack_count <= ack_count + 1;
            end else if (cyc && stb && !ack) begin
                wait_cnt <= wait_cnt + 8'd1;
            end
        end
    end

    // byte address with 8 bytes per word
    always @(posedge clk) begin
        if (hit) begin
            if (we) begin
                mem[adr[11:3]] <= dat_w;
            end
            dat_r <= mem[adr[11:3]];
        end
    end

endmodule
